//--- logic/hist_defs.svh
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// ----------------------------------------------------------------------
// histogram widths
// ----------------------------------------------------------------------

// input sample width
`define HIST_SAMPLE_BITS 8

// bin number width, also the RAM address width
// 6 bits give 64 bins
`define HIST_BIN_BITS 6

// bin count width, also the RAM word width
// narrow on purpose so counts can saturate quickly
`define HIST_COUNT_BITS 8

`endif

//--- logic/hist_types_pkg.sv
`include "hist_defs.svh"

package hist_types_pkg;

	// ------------------------------------------------------------------
	// data widths
	// ------------------------------------------------------------------

	// one input sample
	typedef logic [`HIST_SAMPLE_BITS-1:0] sample_t;

	// one bin number, doubles as RAM address
	typedef logic [`HIST_BIN_BITS-1:0] bin_addr_t;

	// one bin count, doubles as RAM data word
	typedef logic [`HIST_COUNT_BITS-1:0] count_t;

	// ------------------------------------------------------------------
	// dump output
	// ------------------------------------------------------------------

	// one bin as streamed out during a dump
	typedef struct packed {
		bin_addr_t index;
		count_t    count;
	} bin_out_t;

endpackage

//--- logic/hist_ctrl_pkg.sv
`include "hist_defs.svh"

package hist_ctrl_pkg;

	// control FSM states
	typedef enum logic [2:0] {
		IDLE,
		CLEAR,
		ACC_READ,
		ACC_WRITE,
		DUMP
	} ctrl_state_t;

	// one request to the single RAM port
	typedef struct packed {
		logic                     en;
		logic                     we;
		hist_types_pkg::bin_addr_t addr;
		hist_types_pkg::count_t    wdata;
	} ram_req_t;

	// highest bin number, end of the clear and dump sweeps
	localparam hist_types_pkg::bin_addr_t LAST_BIN =
		hist_types_pkg::bin_addr_t'((1 << `HIST_BIN_BITS) - 1);

endpackage

//--- logic/ram_singleport.sv
module ram_singleport #(
	parameter int ADDR_WIDTH  = 8,
	parameter int DATA_WIDTH  = 8,
	parameter bit WRITE_FIRST = 1'b0
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  en,
	input  logic                  we,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic [DATA_WIDTH-1:0] din,
	output logic [DATA_WIDTH-1:0] dout
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	// one word per address
	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (en && we) begin
			mem[addr] <= din;
		end
	end

	// registered read, only moves while enabled
	generate
		if (WRITE_FIRST) begin : g_write_first
			// a write cycle returns the new word
			always_ff @(posedge clk) begin
				if (en) begin
					if (reset) begin
						dout <= '0;
					end else if (we) begin
						dout <= din;
					end else begin
						dout <= mem[addr];
					end
				end
			end
		end else begin : g_read_first
			// a write cycle returns the old contents
			always_ff @(posedge clk) begin
				if (en) begin
					if (reset) begin
						dout <= '0;
					end else begin
						dout <= mem[addr];
					end
				end
			end
		end
	endgenerate

endmodule

//--- logic/hist_bin_map.sv
module hist_bin_map (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      capture,
	input  hist_types_pkg::sample_t   sample,
	input  hist_types_pkg::sample_t   bin_base,
	input  logic [2:0]                bin_shift,
	output hist_types_pkg::bin_addr_t bin
);

	import hist_types_pkg::*;

	localparam int SAMPLE_W = $bits(sample_t);
	localparam int BIN_W    = $bits(bin_addr_t);

	logic      below_base;
	sample_t   offset;
	sample_t   scaled;
	logic      above_top;
	bin_addr_t bin_next;

	// offset from the base, scaled down by the shift
	assign below_base = (sample < bin_base);
	assign offset     = sample - bin_base;
	assign scaled     = offset >> bin_shift;

	// anything left in the upper bits is past the last bin
	assign above_top = |scaled[SAMPLE_W-1:BIN_W];

	// clamp both ends of the range
	always_comb begin
		if (below_base) begin
			bin_next = '0;
		end else if (above_top) begin
			bin_next = '1;
		end else begin
			bin_next = scaled[BIN_W-1:0];
		end
	end

	// hold the bin until the next accepted sample
	always_ff @(posedge clk) begin
		if (reset) begin
			bin <= '0;
		end else if (capture) begin
			bin <= bin_next;
		end
	end

endmodule

//--- logic/hist_count_update.sv
module hist_count_update (
	input  logic                   clk,
	input  logic                   reset,
	input  hist_types_pkg::count_t count_in,
	input  logic                   commit,
	input  logic                   clear_flag,
	output hist_types_pkg::count_t count_next,
	output logic                   saturated
);

	import hist_types_pkg::*;

	logic at_max;

	// count already at its ceiling
	assign at_max = (count_in == '1);

	// ------------------------------------------------------------------
	// saturating increment
	// ------------------------------------------------------------------

	always_comb begin
		if (at_max) begin
			count_next = count_in;
		end else begin
			count_next = count_in + count_t'(1);
		end
	end

	// ------------------------------------------------------------------
	// sticky saturation flag
	// ------------------------------------------------------------------

	// set when a full bin gets another hit
	always_ff @(posedge clk) begin
		if (reset) begin
			saturated <= 1'b0;
		end else if (clear_flag) begin
			saturated <= 1'b0;
		end else if (commit && at_max) begin
			saturated <= 1'b1;
		end
	end

endmodule

//--- logic/hist_ctrl.sv
module hist_ctrl (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       sample_valid,
	input  logic                       clear_start,
	input  logic                       dump_start,
	input  hist_types_pkg::bin_addr_t  bin,
	input  hist_types_pkg::count_t     count_next,
	input  hist_types_pkg::count_t     rdata,
	output hist_ctrl_pkg::ram_req_t    ram_req,
	output logic                       capture,
	output logic                       commit,
	output logic                       clear_flag,
	output logic                       ready,
	output logic                       busy,
	output logic                       bin_valid,
	output hist_types_pkg::bin_out_t   bin_out
);

	import hist_types_pkg::*;
	import hist_ctrl_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	// sweep address for clear and dump
	bin_addr_t cnt_q;

	// last dump read issued, waiting for its data
	logic      drain_q;

	// dump read pipeline, lines up with rdata
	logic      rd_vld_q;
	bin_addr_t rd_idx_q;

	logic      accept;
	logic      sweep_end;
	logic      dump_issue;

	// ------------------------------------------------------------------
	// status and strobes
	// ------------------------------------------------------------------

	// a start pulse takes the idle slot, so no sample is taken with it
	assign ready      = (state_q == IDLE) && !clear_start && !dump_start;
	assign busy       = (state_q != IDLE);
	assign accept     = sample_valid && ready;
	assign capture    = accept;
	assign commit     = (state_q == ACC_WRITE);
	assign clear_flag = (state_q == CLEAR);

	assign sweep_end  = (cnt_q == LAST_BIN);
	assign dump_issue = (state_q == DUMP) && !drain_q;

	// ------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (clear_start) begin
					state_d = CLEAR;
				end else if (dump_start) begin
					state_d = DUMP;
				end else if (accept) begin
					state_d = ACC_READ;
				end
			end
			CLEAR: begin
				if (sweep_end) begin
					state_d = IDLE;
				end
			end
			ACC_READ:  state_d = ACC_WRITE;
			ACC_WRITE: state_d = IDLE;
			DUMP: begin
				// one extra cycle for the last read to return
				if (drain_q) begin
					state_d = IDLE;
				end
			end
			default:   state_d = IDLE;
		endcase
	end

	// clear runs first out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= CLEAR;
		end else begin
			state_q <= state_d;
		end
	end

	// ------------------------------------------------------------------
	// sweep counter
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt_q   <= '0;
			drain_q <= 1'b0;
		end else begin
			if (state_q == CLEAR || dump_issue) begin
				cnt_q <= cnt_q + bin_addr_t'(1);
			end else if (state_q == IDLE) begin
				cnt_q <= '0;
			end
			drain_q <= dump_issue && sweep_end;
		end
	end

	// ------------------------------------------------------------------
	// RAM port
	// ------------------------------------------------------------------

	always_comb begin
		ram_req = '0;
		case (state_q)
			CLEAR: begin
				ram_req.en   = 1'b1;
				ram_req.we   = 1'b1;
				ram_req.addr = cnt_q;
			end
			ACC_READ: begin
				ram_req.en   = 1'b1;
				ram_req.addr = bin;
			end
			ACC_WRITE: begin
				// write back the incremented count
				ram_req.en    = 1'b1;
				ram_req.we    = 1'b1;
				ram_req.addr  = bin;
				ram_req.wdata = count_next;
			end
			DUMP: begin
				ram_req.en   = !drain_q;
				ram_req.addr = cnt_q;
			end
			default: begin
				ram_req = '0;
			end
		endcase
	end

	// ------------------------------------------------------------------
	// dump output
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_vld_q <= 1'b0;
		end else begin
			rd_vld_q <= dump_issue;
		end
	end

	always_ff @(posedge clk) begin
		rd_idx_q <= cnt_q;
	end

	assign bin_valid     = rd_vld_q;
	assign bin_out.index = rd_idx_q;
	assign bin_out.count = rdata;

endmodule

//--- logic/hist_top.sv
`include "hist_defs.svh"

module hist_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     sample_valid,
	input  hist_types_pkg::sample_t  sample,
	input  logic                     clear_start,
	input  logic                     dump_start,
	input  hist_types_pkg::sample_t  bin_base,
	input  logic [2:0]               bin_shift,
	output logic                     ready,
	output logic                     busy,
	output logic                     bin_valid,
	output hist_types_pkg::bin_out_t bin_out,
	output logic                     saturated
);

	import hist_types_pkg::*;
	import hist_ctrl_pkg::*;

	ram_req_t  ram_req;
	bin_addr_t bin;
	count_t    rdata;
	count_t    count_next;
	logic      capture;
	logic      commit;
	logic      clear_flag;

	// ------------------------------------------------------------------
	// control FSM
	// ------------------------------------------------------------------

	hist_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.clear_start  (clear_start),
		.dump_start   (dump_start),
		.bin          (bin),
		.count_next   (count_next),
		.rdata        (rdata),
		.ram_req      (ram_req),
		.capture      (capture),
		.commit       (commit),
		.clear_flag   (clear_flag),
		.ready        (ready),
		.busy         (busy),
		.bin_valid    (bin_valid),
		.bin_out      (bin_out)
	);

	// sample to bin
	hist_bin_map u_bin_map (
		.clk       (clk),
		.reset     (reset),
		.capture   (capture),
		.sample    (sample),
		.bin_base  (bin_base),
		.bin_shift (bin_shift),
		.bin       (bin)
	);

	// increment and saturation tracking
	hist_count_update u_count_update (
		.clk        (clk),
		.reset      (reset),
		.count_in   (rdata),
		.commit     (commit),
		.clear_flag (clear_flag),
		.count_next (count_next),
		.saturated  (saturated)
	);

	// ------------------------------------------------------------------
	// bin storage, read-first
	// ------------------------------------------------------------------

	ram_singleport #(
		.ADDR_WIDTH  (`HIST_BIN_BITS),
		.DATA_WIDTH  (`HIST_COUNT_BITS),
		.WRITE_FIRST (1'b0)
	) u_ram (
		.clk   (clk),
		.reset (reset),
		.en    (ram_req.en),
		.we    (ram_req.we),
		.addr  (ram_req.addr),
		.din   (ram_req.wdata),
		.dout  (rdata)
	);

endmodule

//--- dv/hist_assertions.sv
module hist_assertions (
	input logic                     clk,
	input logic                     reset,
	input logic                     sample_valid,
	input logic                     ready,
	input logic                     busy,
	input logic                     bin_valid,
	input hist_types_pkg::bin_out_t bin_out,
	input logic                     saturated,
	input logic                     clear_flag
);

	timeunit 1ns;
	timeprecision 1ps;

	import hist_types_pkg::*;

	int   fail_count = 0;
	logic accept;

	assign accept = sample_valid && ready;

	// ----------------------------------------------------------------------
	// accumulate and status
	// ----------------------------------------------------------------------

	// no new sample during the read-modify-write
	a_rmw_read: assert property (@(posedge clk) disable iff (reset)
		$past(accept) |-> !ready)
		else begin
			$error("ready high one cycle after an accepted sample");
			fail_count++;
		end

	a_rmw_write: assert property (@(posedge clk) disable iff (reset)
		$past(accept, 2) |-> !ready)
		else begin
			$error("ready high two cycles after an accepted sample");
			fail_count++;
		end

	a_busy_ready: assert property (@(posedge clk) disable iff (reset)
		!(busy && ready))
		else begin
			$error("busy and ready high together");
			fail_count++;
		end

	// sticky until reset or clear
	a_sat_sticky: assert property (@(posedge clk) disable iff (reset)
		$fell(saturated) |-> ($past(reset) || $past(clear_flag)))
		else begin
			$error("saturated fell without reset or clear");
			fail_count++;
		end

	// ----------------------------------------------------------------------
	// dump stream
	// ----------------------------------------------------------------------

	a_dump_first: assert property (@(posedge clk) disable iff (reset)
		(bin_valid && !$past(bin_valid)) |-> (bin_out.index == '0))
		else begin
			$error("dump did not start at bin 0");
			fail_count++;
		end

	a_dump_step: assert property (@(posedge clk) disable iff (reset)
		(bin_valid && $past(bin_valid)) |->
			(bin_out.index == bin_addr_t'($past(bin_out.index) + 1'b1)))
		else begin
			$error("dump index did not step by one");
			fail_count++;
		end

	a_dump_last: assert property (@(posedge clk) disable iff (reset)
		(!bin_valid && $past(bin_valid)) |-> ($past(bin_out.index) == '1))
		else begin
			$error("dump ended before the last bin");
			fail_count++;
		end

endmodule

bind hist_top hist_assertions u_assertions (
	.clk          (clk),
	.reset        (reset),
	.sample_valid (sample_valid),
	.ready        (ready),
	.busy         (busy),
	.bin_valid    (bin_valid),
	.bin_out      (bin_out),
	.saturated    (saturated),
	.clear_flag   (clear_flag)
);

//--- dv/hist_tb.sv
`include "hist_defs.svh"

module hist_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import hist_types_pkg::*;

	localparam int NUM_BINS  = 1 << `HIST_BIN_BITS;
	localparam int MAX_COUNT = (1 << `HIST_COUNT_BITS) - 1;

	// reset plus about five cycles per sample plus dumps, clears and margin
	localparam int LIMIT_CYCLES = 16 + 908 * 5 + 5 * 70 + 4 * 70 + 1000;

	logic       clk;
	logic       reset;
	logic       sample_valid;
	sample_t    sample;
	logic       clear_start;
	logic       dump_start;
	sample_t    bin_base;
	logic [2:0] bin_shift;
	logic       ready;
	logic       busy;
	logic       bin_valid;
	bin_out_t   bin_out;
	logic       saturated;

	// reference histogram
	int          model [NUM_BINS];
	logic        model_sat;
	int          errors;
	int          busy_cycles;
	logic [31:0] rng;
	sample_t     edge_samples [8] = '{
		8'd0, 8'd30, 8'd63, 8'd64, 8'd100, 8'd126, 8'd127, 8'd255
	};

	hist_top DUT (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// clamp below the base and past the last bin
	function automatic int expected_bin(input int s, input int base, input int shift);
		int v;
		if (s < base) begin
			v = 0;
		end else begin
			v = (s - base) >> shift;
		end
		return (v > NUM_BINS - 1) ? NUM_BINS - 1 : v;
	endfunction

	task automatic check_equal(input int got, input int exp, input string what);
		assert (got == exp) else begin
			errors++;
			$display("FAILED at %0d ns: %s, got %0d, expected %0d",
				$time, what, got, exp);
		end
	endtask

	task automatic wait_idle();
		while (busy) @(negedge clk);
	endtask

	// poke_busy keeps sample_valid high while ready is low
	task automatic send_sample(input sample_t s, input bit poke_busy);
		int b;
		while (!ready) @(negedge clk);
		sample_valid = 1'b1;
		sample       = s;
		b = expected_bin(int'(s), int'(bin_base), int'(bin_shift));
		if (model[b] == MAX_COUNT) begin
			model_sat = 1'b1;
		end else begin
			model[b]++;
		end
		@(negedge clk);
		sample_valid = poke_busy;
		sample       = ~s;
		if (poke_busy) begin
			@(negedge clk);
			@(negedge clk);
			sample_valid = 1'b0;
		end
	endtask

	task automatic run_clear();
		wait_idle();
		clear_start = 1'b1;
		@(negedge clk);
		clear_start = 1'b0;
		for (int i = 0; i < NUM_BINS; i++) begin
			model[i] = 0;
		end
		model_sat = 1'b0;
		wait_idle();
	endtask

	// bins expected on the 2nd to 65th cycle after dump_start
	task automatic run_dump();
		bit want;
		wait_idle();
		dump_start = 1'b1;
		for (int k = 1; k <= 67; k++) begin
			@(negedge clk);
			dump_start = 1'b0;
			want = (k >= 2) && (k <= NUM_BINS + 1);
			check_equal(int'(bin_valid), int'(want), "bin_valid timing");
			if (want && bin_valid) begin
				check_equal(int'(bin_out.index), k - 2, "bin index");
				check_equal(int'(bin_out.count), model[k - 2],
					$sformatf("count of bin %0d", k - 2));
			end
		end
		check_equal(int'(busy), 0, "busy after dump");
		check_equal(int'(saturated), int'(model_sat), "saturated flag");
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(LIMIT_CYCLES * 100);
		$display("timeout: the histogram unit did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		reset        = 1'b1;
		sample_valid = 1'b0;
		sample       = '0;
		clear_start  = 1'b0;
		dump_start   = 1'b0;
		bin_base     = '0;
		bin_shift    = 3'd2;
		errors       = 0;
		rng          = 32'd47;
		model_sat    = 1'b0;
		for (int i = 0; i < NUM_BINS; i++) begin
			model[i] = 0;
		end
		repeat (16) @(negedge clk);
		reset = 1'b0;

		// ----------------------------------------------------------------------
		// clear sweep after reset
		// ----------------------------------------------------------------------
		busy_cycles = 0;
		while (busy) begin
			check_equal(int'(ready), 0, "ready during clear");
			busy_cycles++;
			@(negedge clk);
		end
		check_equal(busy_cycles, NUM_BINS, "busy cycles after reset");
		run_dump();

		// random samples with sample_valid now and then held through busy cycles
		for (int i = 0; i < 500; i++) begin
			rng = xorshift(rng);
			send_sample(sample_t'(rng[7:0]), (i % 25) == 0);
		end
		run_dump();

		// clamping at both ends
		run_clear();
		bin_base  = 8'd64;
		bin_shift = 3'd0;
		foreach (edge_samples[i]) begin
			send_sample(edge_samples[i], 1'b0);
		end
		for (int i = 0; i < 100; i++) begin
			rng = xorshift(rng);
			send_sample(sample_t'(rng[7:0]), 1'b0);
		end
		run_dump();

		// ----------------------------------------------------------------------
		// saturation and clear
		// ----------------------------------------------------------------------
		run_clear();
		bin_base = '0;
		for (int i = 0; i < 300; i++) begin
			send_sample(8'd42, 1'b0);
		end
		wait_idle();
		check_equal(int'(saturated), 1, "saturated after 300 hits");
		run_dump();
		run_clear();
		check_equal(int'(saturated), 0, "saturated after clear");
		run_dump();

		$display("errors: %0d check failures, %0d assertion failures",
			errors, DUT.u_assertions.fail_count);
		if (errors == 0 && DUT.u_assertions.fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- hist.f
+incdir+logic
logic/hist_types_pkg.sv
logic/hist_ctrl_pkg.sv
logic/ram_singleport.sv
logic/hist_bin_map.sv
logic/hist_count_update.sv
logic/hist_ctrl.sv
logic/hist_top.sv
dv/hist_assertions.sv
dv/hist_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module hist_tb -f hist.f -o hist_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/hist_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
exit 0
